//--- filelist.f
src/game_pkg.sv
src/ctrl_pkg.sv
src/key_decoder.sv
src/game_timer.sv
src/player_mover.sv
src/game_fsm.sv
src/plot_datapath.sv
src/board_ram.sv
src/score_counter.sv
src/turf_top.sv
testbench/turf_sva.sv
testbench/turf_tb.sv

//--- src/board_ram.sv
`timescale 1ns/1ns
`default_nettype none

// Address is {x, y}, so only x below 160 is ever touched
module board_ram (
  input  logic        CLOCK_50,
  input  logic        we,
  input  logic [14:0] addr,
  input  logic [2:0]  wdata,
  output logic [2:0]  rdata
);

  logic [2:0] mem [0:32767];

  always_ff @(posedge CLOCK_50)
  begin
    if (we)
      mem[addr] <= wdata;
    rdata <= mem[addr];  // Old data on a write cycle
  end

endmodule

`default_nettype wire

//--- src/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

  typedef enum logic [3:0] {
    st_idle, st_clear_write, st_clear_next,
    st_draw_p0, st_draw_p1, st_draw_p2, st_draw_p3,
    st_play_wait, st_tally, st_done
  } game_state_t;

  // Player opcodes are player * 4 + direction
  typedef enum logic [4:0] {
    key_p0_up = 5'd0, key_p0_down = 5'd1, key_p0_left = 5'd2, key_p0_right = 5'd3,
    key_p1_up = 5'd4, key_p1_down = 5'd5, key_p1_left = 5'd6, key_p1_right = 5'd7,
    key_p2_up = 5'd8, key_p2_down = 5'd9, key_p2_left = 5'd10, key_p2_right = 5'd11,
    key_p3_up = 5'd12, key_p3_down = 5'd13, key_p3_left = 5'd14, key_p3_right = 5'd15,
    key_start = 5'd16
  } key_op_t;

endpackage

`default_nettype wire

//--- src/game_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module game_fsm import ctrl_pkg::*, game_pkg::*; (
  input  logic       CLOCK_50,
  input  logic       reset,
  input  logic       start_pulse,
  input  logic       clear_done,
  input  logic       move_tick,
  input  logic       round_over,
  input  logic       tally_done,
  output logic       in_idle,
  output logic       load_start,
  output logic       play_active,
  output logic       clear_write,
  output logic       clear_next,
  output logic       draw_en,
  output logic       tally_start,
  output player_id_t draw_sel
);

  game_state_t state, state_nx;
  logic        tick_pend;  // Tick that arrived while drawing
  logic        tick_seen;

  assign tick_seen = move_tick || tick_pend;

  always_ff @(posedge CLOCK_50)
  begin
    if (reset)
    begin
      state     <= st_idle;
      tick_pend <= 1'b0;
    end
    else
    begin
      state <= state_nx;
      if (state == st_play_wait)
        tick_pend <= 1'b0;
      else if (move_tick)
        tick_pend <= 1'b1;
    end
  end

  always_comb
  begin
    state_nx = state;
    case (state)
      st_idle:        if (start_pulse) state_nx = st_clear_write;
      st_clear_write: state_nx = st_clear_next;
      st_clear_next:  state_nx = clear_done ? st_draw_p0 : st_clear_write;
      st_draw_p0:     state_nx = st_draw_p1;
      st_draw_p1:     state_nx = st_draw_p2;
      st_draw_p2:     state_nx = st_draw_p3;
      st_draw_p3:     state_nx = st_play_wait;
      st_play_wait:
        if (tick_seen)
          state_nx = st_draw_p0;
        else if (round_over)
          state_nx = st_tally;  // Last draws are already written
      st_tally:       if (tally_done) state_nx = st_done;
      st_done:        state_nx = st_done;
      default:        state_nx = st_idle;
    endcase
  end

  assign in_idle     = (state == st_idle);
  assign clear_write = (state == st_clear_write);
  assign clear_next  = (state == st_clear_next);
  assign load_start  = clear_next && clear_done;
  assign draw_en     = state inside {st_draw_p0, st_draw_p1, st_draw_p2, st_draw_p3};
  assign play_active = draw_en || (state == st_play_wait);
  assign tally_start = (state == st_play_wait) && round_over && !tick_seen;

  always_comb
  begin
    case (state)
      st_draw_p1: draw_sel = 2'd1;
      st_draw_p2: draw_sel = 2'd2;
      st_draw_p3: draw_sel = 2'd3;
      default:    draw_sel = 2'd0;
    endcase
  end

endmodule

`default_nettype wire

//--- src/game_pkg.sv
`default_nettype none

package game_pkg;

  // Board size in cells
  localparam int board_w_c = 160;
  localparam int board_h_c = 120;

  typedef logic [7:0] coord_x_t;
  typedef logic [6:0] coord_y_t;
  typedef logic [2:0] colour_t;   // One bit each of blue, green, red
  typedef logic [1:0] player_id_t;
  typedef logic [14:0] score_t;   // Enough for all 19200 cells

  typedef enum logic [1:0] {
    dir_up,
    dir_down,
    dir_left,
    dir_right
  } dir_t;

  localparam colour_t colour_black_c = 3'b000;  // Cleared cell

  // Blue, green, red, yellow
  localparam colour_t player_colour_c [0:3] = '{3'b001, 3'b010, 3'b100, 3'b110};

  // One player near each corner
  localparam coord_x_t start_x_c [0:3] = '{8'd8, 8'd151, 8'd8, 8'd151};
  localparam coord_y_t start_y_c [0:3] = '{7'd8, 7'd8, 7'd111, 7'd111};

endpackage

`default_nettype wire

//--- src/game_timer.sv
`timescale 1ns/1ns
`default_nettype none

module game_timer #(
  parameter int TICK_CYCLES = 50000,
  parameter int GAME_TICKS  = 600
) (
  input  logic CLOCK_50,
  input  logic reset,
  input  logic play_active,
  output logic move_tick,
  output logic round_over
);

  localparam int div_w_c  = $clog2(TICK_CYCLES + 1);
  localparam int tick_w_c = $clog2(GAME_TICKS + 1);

  logic [div_w_c-1:0]  div_cnt;
  logic [tick_w_c-1:0] tick_cnt;  // Ticks so far this round
  logic                div_wrap;

  assign div_wrap = (div_cnt == div_w_c'(TICK_CYCLES - 1));

  always_ff @(posedge CLOCK_50)
  begin
    if (reset || !play_active)  // Fresh count each round
    begin
      div_cnt    <= '0;
      tick_cnt   <= '0;
      move_tick  <= 1'b0;
      round_over <= 1'b0;
    end
    else
    begin
      move_tick <= 1'b0;
      if (!round_over)  // No more ticks once the round is over
      begin
        if (div_wrap)
        begin
          div_cnt   <= '0;
          move_tick <= 1'b1;
          tick_cnt  <= tick_cnt + 1'b1;
          if (tick_cnt == tick_w_c'(GAME_TICKS - 1))
            round_over <= 1'b1;
        end
        else
          div_cnt <= div_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- src/key_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module key_decoder import ctrl_pkg::*, game_pkg::*; (
  input  logic    CLOCK_50,
  input  logic    reset,
  input  logic    key_valid,
  input  key_op_t key_op,
  output logic    key_ready,
  input  logic    in_idle,
  output dir_t    dir_p0,
  output dir_t    dir_p1,
  output dir_t    dir_p2,
  output dir_t    dir_p3,
  output logic    start_pulse
);

  always_ff @(posedge CLOCK_50)
  begin
    if (reset)
    begin
      key_ready   <= 1'b0;
      start_pulse <= 1'b0;
      dir_p0      <= dir_right;
      dir_p1      <= dir_right;
      dir_p2      <= dir_right;
      dir_p3      <= dir_right;
    end
    else
    begin
      key_ready   <= 1'b1;  // Never refuses an opcode
      start_pulse <= 1'b0;
      if (key_valid && key_ready)
      begin
        if (key_op == key_start)
          start_pulse <= in_idle;  // Start only counts from idle
        else if (!key_op[4])
        begin
          case (key_op[3:2])  // Player index field
            2'd0: dir_p0 <= dir_t'(key_op[1:0]);
            2'd1: dir_p1 <= dir_t'(key_op[1:0]);
            2'd2: dir_p2 <= dir_t'(key_op[1:0]);
            default: dir_p3 <= dir_t'(key_op[1:0]);
          endcase
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- src/player_mover.sv
`timescale 1ns/1ns
`default_nettype none

module player_mover import game_pkg::*; (
  input  logic     CLOCK_50,
  input  logic     reset,
  input  logic     load_start,
  input  logic     move_tick,
  input  dir_t     dir_p0,
  input  dir_t     dir_p1,
  input  dir_t     dir_p2,
  input  dir_t     dir_p3,
  output coord_x_t pos_x_p0,
  output coord_x_t pos_x_p1,
  output coord_x_t pos_x_p2,
  output coord_x_t pos_x_p3,
  output coord_y_t pos_y_p0,
  output coord_y_t pos_y_p1,
  output coord_y_t pos_y_p2,
  output coord_y_t pos_y_p3
);

  dir_t     dir_a [0:3];
  coord_x_t pos_x [0:3];
  coord_y_t pos_y [0:3];

  assign dir_a = '{dir_p0, dir_p1, dir_p2, dir_p3};

  // Clamped at the left and right edges
  function automatic coord_x_t step_x(input coord_x_t x, input dir_t d);
    coord_x_t nx;
    nx = x;
    if (d == dir_left && x != '0)
      nx = x - 1'b1;
    else if (d == dir_right && x != coord_x_t'(board_w_c - 1))
      nx = x + 1'b1;
    return nx;
  endfunction

  function automatic coord_y_t step_y(input coord_y_t y, input dir_t d);
    coord_y_t ny;
    ny = y;
    if (d == dir_up && y != '0)
      ny = y - 1'b1;
    else if (d == dir_down && y != coord_y_t'(board_h_c - 1))
      ny = y + 1'b1;
    return ny;
  endfunction

  always_ff @(posedge CLOCK_50)
  begin
    for (int p = 0; p < 4; p++)
    begin
      if (reset || load_start)
      begin
        pos_x[p] <= start_x_c[p];
        pos_y[p] <= start_y_c[p];
      end
      else if (move_tick)
      begin
        pos_x[p] <= step_x(pos_x[p], dir_a[p]);
        pos_y[p] <= step_y(pos_y[p], dir_a[p]);
      end
    end
  end

  assign {pos_x_p0, pos_x_p1, pos_x_p2, pos_x_p3} = {pos_x[0], pos_x[1], pos_x[2], pos_x[3]};
  assign {pos_y_p0, pos_y_p1, pos_y_p2, pos_y_p3} = {pos_y[0], pos_y[1], pos_y[2], pos_y[3]};

endmodule

`default_nettype wire

//--- src/plot_datapath.sv
`timescale 1ns/1ns
`default_nettype none

module plot_datapath import game_pkg::*; (
  input  logic       CLOCK_50,
  input  logic       reset,
  input  logic       clear_write,
  input  logic       clear_next,
  input  logic       draw_en,
  input  player_id_t draw_sel,
  input  coord_x_t   pos_x_p0,
  input  coord_x_t   pos_x_p1,
  input  coord_x_t   pos_x_p2,
  input  coord_x_t   pos_x_p3,
  input  coord_y_t   pos_y_p0,
  input  coord_y_t   pos_y_p1,
  input  coord_y_t   pos_y_p2,
  input  coord_y_t   pos_y_p3,
  output logic       clear_done,
  output logic       plot_valid,
  output coord_x_t   plot_x,
  output coord_y_t   plot_y,
  output colour_t    plot_colour
);

  coord_x_t clr_x;  // Clear raster, x runs fastest
  coord_y_t clr_y;
  coord_x_t sel_x [0:3];
  coord_y_t sel_y [0:3];
  logic     clr_row_end;

  assign sel_x       = '{pos_x_p0, pos_x_p1, pos_x_p2, pos_x_p3};
  assign sel_y       = '{pos_y_p0, pos_y_p1, pos_y_p2, pos_y_p3};
  assign clr_row_end = (clr_x == coord_x_t'(board_w_c - 1));
  assign clear_done  = clr_row_end && (clr_y == coord_y_t'(board_h_c - 1));

  always_ff @(posedge CLOCK_50)
  begin
    if (reset)
    begin
      clr_x      <= '0;
      clr_y      <= '0;
      plot_valid <= 1'b0;
    end
    else
    begin
      plot_valid <= clear_write || draw_en;
      if (clear_next)
      begin
        clr_x <= clr_row_end ? '0 : clr_x + 1'b1;
        if (clr_row_end)
          clr_y <= clear_done ? '0 : clr_y + 1'b1;  // Wraps for the next game
      end
    end
  end

  always_ff @(posedge CLOCK_50)
  begin
    if (clear_write)
    begin
      plot_x      <= clr_x;
      plot_y      <= clr_y;
      plot_colour <= colour_black_c;
    end
    else if (draw_en)
    begin
      plot_x      <= sel_x[draw_sel];
      plot_y      <= sel_y[draw_sel];
      plot_colour <= player_colour_c[draw_sel];
    end
  end

endmodule

`default_nettype wire

//--- src/score_counter.sv
`timescale 1ns/1ns
`default_nettype none

module score_counter import game_pkg::*; (
  input  logic        CLOCK_50,
  input  logic        reset,
  input  logic        tally_start,
  input  colour_t     rdata,
  output logic [14:0] rd_addr,
  output logic        tally_active,
  output logic        tally_done,
  output logic        result_valid,
  output score_t      score_p0,
  output score_t      score_p1,
  output score_t      score_p2,
  output score_t      score_p3,
  output player_id_t  rank_first,
  output player_id_t  rank_second,
  output player_id_t  rank_third,
  output player_id_t  rank_fourth
);

  typedef enum logic [2:0] {sc_idle, sc_addr, sc_count, sc_rank, sc_done} sc_state_t;

  sc_state_t  state;
  coord_x_t   scan_x;
  coord_y_t   scan_y;
  logic       row_end;
  score_t     cnt [0:3];
  logic [1:0] place [0:3];  // Finishing position of each player
  player_id_t rank_q [0:3];

  assign row_end      = (scan_x == coord_x_t'(board_w_c - 1));
  assign rd_addr      = {scan_x, scan_y};
  assign tally_active = (state == sc_addr) || (state == sc_count);
  assign tally_done   = (state == sc_done);

  always_ff @(posedge CLOCK_50)
  begin
    if (reset)
    begin
      state        <= sc_idle;
      result_valid <= 1'b0;
      scan_x       <= '0;
      scan_y       <= '0;
      cnt          <= '{default: '0};
    end
    else
    begin
      case (state)
        sc_idle:
          if (tally_start)
          begin
            state  <= sc_addr;
            scan_x <= '0;
            scan_y <= '0;
            cnt    <= '{default: '0};
          end
        sc_addr: state <= sc_count;  // RAM data comes back next cycle
        sc_count:
        begin
          for (int p = 0; p < 4; p++)
            if (rdata == player_colour_c[p])
              cnt[p] <= cnt[p] + 1'b1;
          if (row_end && scan_y == coord_y_t'(board_h_c - 1))
            state <= sc_rank;
          else
          begin
            scan_x <= row_end ? '0 : scan_x + 1'b1;
            scan_y <= row_end ? scan_y + 1'b1 : scan_y;
            state  <= sc_addr;
          end
        end
        sc_rank:
        begin
          result_valid <= 1'b1;  // Held until reset
          state        <= sc_done;
        end
        default: state <= sc_done;
      endcase
    end
  end

  // Pairwise compare, ties go to the lower index
  always_comb
  begin
    for (int i = 0; i < 4; i++)
    begin
      place[i] = 2'd0;
      for (int j = 0; j < 4; j++)
        if (j != i && (cnt[j] > cnt[i] || (cnt[j] == cnt[i] && j < i)))
          place[i] = place[i] + 1'b1;
    end
  end

  always_ff @(posedge CLOCK_50)
  begin
    if (state == sc_rank)
      for (int i = 0; i < 4; i++)
        rank_q[place[i]] <= player_id_t'(i);
  end

  assign {score_p0, score_p1, score_p2, score_p3} = {cnt[0], cnt[1], cnt[2], cnt[3]};
  assign rank_first  = rank_q[0];
  assign rank_second = rank_q[1];
  assign rank_third  = rank_q[2];
  assign rank_fourth = rank_q[3];

endmodule

`default_nettype wire

//--- src/turf_top.sv
`timescale 1ns/1ns
`default_nettype none

module turf_top import ctrl_pkg::*, game_pkg::*; #(
  parameter int TICK_CYCLES = 50000,
  parameter int GAME_TICKS  = 600
) (
  input  logic       CLOCK_50,
  input  logic       reset,
  input  logic       key_valid,
  input  key_op_t    key_op,
  output logic       key_ready,
  output logic       plot_valid,
  output coord_x_t   plot_x,
  output coord_y_t   plot_y,
  output colour_t    plot_colour,
  output logic       result_valid,
  output score_t     score_p0,
  output score_t     score_p1,
  output score_t     score_p2,
  output score_t     score_p3,
  output player_id_t rank_first,
  output player_id_t rank_second,
  output player_id_t rank_third,
  output player_id_t rank_fourth
);

  dir_t        dir_p0, dir_p1, dir_p2, dir_p3;
  coord_x_t    pos_x_p0, pos_x_p1, pos_x_p2, pos_x_p3;
  coord_y_t    pos_y_p0, pos_y_p1, pos_y_p2, pos_y_p3;
  logic        start_pulse, in_idle, load_start, play_active;
  logic        move_tick, round_over;
  logic        clear_write, clear_next, clear_done, draw_en;
  player_id_t  draw_sel;
  logic        tally_start, tally_active, tally_done;
  logic [14:0] rd_addr, ram_addr;
  logic [2:0]  ram_rdata;

  // Scanner owns the RAM port during tally
  assign ram_addr = tally_active ? rd_addr : {plot_x, plot_y};

  key_decoder u_key_decoder (.*);

  game_timer #(
    .TICK_CYCLES (TICK_CYCLES),
    .GAME_TICKS  (GAME_TICKS)
  ) u_game_timer (.*);

  player_mover u_player_mover (.*);

  game_fsm u_game_fsm (.*);

  plot_datapath u_plot_datapath (.*);

  board_ram u_board_ram (
    .CLOCK_50 (CLOCK_50),
    .we       (plot_valid),
    .addr     (ram_addr),
    .wdata    (plot_colour),
    .rdata    (ram_rdata)
  );

  score_counter u_score_counter (.*, .rdata(ram_rdata));

endmodule

`default_nettype wire

//--- testbench/turf_sva.sv
`timescale 1ns/1ns
`default_nettype none

module turf_sva import game_pkg::*; (
  input logic     CLOCK_50,
  input logic     reset,
  input logic     hold_flag,  // Sticky once raised
  input logic     wr_valid,
  input coord_x_t wr_x,
  input coord_y_t wr_y
);

  hold_stays_high: assert property (@(posedge CLOCK_50) disable iff (reset)
    hold_flag |=> hold_flag)
    else $error("result_valid fell while reset was low");

  x_on_board: assert property (@(posedge CLOCK_50) disable iff (reset)
    wr_valid |-> wr_x < coord_x_t'(board_w_c))
    else $error("plot_x is off the board");

  y_on_board: assert property (@(posedge CLOCK_50) disable iff (reset)
    wr_valid |-> wr_y < coord_y_t'(board_h_c))
    else $error("plot_y is off the board");

endmodule

bind score_counter turf_sva u_score_sva (
  .CLOCK_50  (CLOCK_50),
  .reset     (reset),
  .hold_flag (result_valid),
  .wr_valid  (1'b0),
  .wr_x      ('0),
  .wr_y      ('0)
);

bind plot_datapath turf_sva u_plot_sva (
  .CLOCK_50  (CLOCK_50),
  .reset     (reset),
  .hold_flag (1'b0),
  .wr_valid  (plot_valid),
  .wr_x      (plot_x),
  .wr_y      (plot_y)
);

`default_nettype wire

//--- testbench/turf_tb.sv
`timescale 1ns/1ns
`default_nettype none

module turf_tb import ctrl_pkg::*, game_pkg::*; ();

  localparam int tick_cycles_c  = 40;
  localparam int game_ticks_c   = 30;
  localparam int cells_c        = board_w_c * board_h_c;
  // Clear sweep, play with its draws, tally scan, plus a margin
  localparam int limit_cycles_c = 2 * cells_c + (game_ticks_c + 1) * (tick_cycles_c + 8)
                                  + 2 * cells_c + 16 + 1000;

  logic       CLOCK_50;
  logic       reset;
  logic       key_valid;
  key_op_t    key_op;
  logic       key_ready;
  logic       plot_valid;
  coord_x_t   plot_x;
  coord_y_t   plot_y;
  colour_t    plot_colour;
  logic       result_valid;
  score_t     score_p0, score_p1, score_p2, score_p3;
  player_id_t rank_first, rank_second, rank_third, rank_fourth;

  int       errors = 0;
  int       checks = 0;
  logic     started;
  bit       cleared [0:board_w_c-1][0:board_h_c-1];
  colour_t  shadow [0:board_w_c-1][0:board_h_c-1];  // Board as seen on the plot port
  int       clear_cnt = 0;
  int       player_plots = 0;
  coord_x_t last_x [0:3];
  coord_y_t last_y [0:3];
  bit       seen [0:3];
  bit       pend [0:3];      // Key accepted, move not yet seen
  int       pend_dir [0:3];

  turf_top #(
    .TICK_CYCLES (tick_cycles_c),
    .GAME_TICKS  (game_ticks_c)
  ) u_turf_top (.*);

  task automatic check_value(input string name, input int expected, input int actual);
    checks++;
    if (expected != actual)
    begin
      errors++;
      $display("[ERROR] %s: expected %0d, actual %0d", name, expected, actual);
    end
  endtask

  // Highest score first and the lower index first on a tie
  function automatic logic [7:0] ref_rank(input int s0, input int s1, input int s2,
                                          input int s3);
    int         sc [0:3];
    bit         taken [0:3];
    logic [7:0] order;
    int         best;
    sc    = '{s0, s1, s2, s3};
    taken = '{default: 1'b0};
    order = '0;
    for (int k = 0; k < 4; k++)
    begin
      best = -1;
      for (int p = 0; p < 4; p++)
        if (!taken[p] && (best < 0 || sc[p] > sc[best]))
          best = p;
      taken[best] = 1'b1;
      order[7 - 2 * k -: 2] = best[1:0];
    end
    return order;
  endfunction

  function automatic int dir_of(input int dx, input int dy);
    if (dy < 0)
      return int'(dir_up);
    else if (dy > 0)
      return int'(dir_down);
    else if (dx < 0)
      return int'(dir_left);
    return int'(dir_right);
  endfunction

  task automatic send_key(input key_op_t op);
    @(posedge CLOCK_50);
    #1;
    key_valid = 1'b1;
    key_op    = op;
    check_value("key_ready while key_valid", 1, key_ready);
    @(posedge CLOCK_50);
    #1;
    key_valid = 1'b0;
  endtask

  // Returns after the yellow plot that closes a draw group
  task automatic wait_draw_group();
    @(negedge CLOCK_50);
    while (!(plot_valid && plot_colour == player_colour_c[3]))
      @(negedge CLOCK_50);
  endtask

  initial
  begin
    CLOCK_50 = 1'b0;
    forever #5 CLOCK_50 = ~CLOCK_50;
  end

  initial
  begin
    void'($urandom(10));
    reset     = 1'b1;
    key_valid = 1'b0;
    key_op    = key_p0_up;
    started   = 1'b0;
    repeat (3) @(posedge CLOCK_50);
    #1 reset = 1'b0;
    @(posedge CLOCK_50);
    for (int p = 0; p < 4; p++)  // One direction per player before start
      send_key(key_op_t'(5'(p * 4 + int'($urandom % 4))));
    repeat (5) @(posedge CLOCK_50);
    send_key(key_start);
    started = 1'b1;
    repeat (game_ticks_c)
    begin
      wait_draw_group();
      if ($urandom % 2)
        send_key(key_op_t'(5'($urandom % 16)));
    end
  end

  always @(negedge CLOCK_50)
  begin : monitor
    int p;
    int dx;
    int dy;
    if (!reset && plot_valid)
    begin
      if (!started)
        check_value("plot_valid before start", 0, 1);
      else if (int'(plot_x) >= board_w_c || int'(plot_y) >= board_h_c)
        check_value("plot inside board", 1, 0);
      else
      begin
        shadow[plot_x][plot_y] = plot_colour;
        p = -1;
        for (int q = 0; q < 4; q++)
          if (plot_colour == player_colour_c[q])
            p = q;
        if (plot_colour == colour_black_c)
        begin
          check_value("black plot after first player plot", 0, player_plots);
          check_value("clear writes to one cell", 0, cleared[plot_x][plot_y]);
          cleared[plot_x][plot_y] = 1'b1;
          clear_cnt++;
        end
        else if (p < 0)
          check_value("plot colour is a player colour", 1, 0);
        else
        begin
          if (player_plots == 0)
            check_value("cells cleared before play", cells_c, clear_cnt);
          if (player_plots < 4)
          begin
            check_value("first plot colour", player_colour_c[player_plots], plot_colour);
            check_value("first plot x", start_x_c[player_plots], plot_x);
            check_value("first plot y", start_y_c[player_plots], plot_y);
          end
          if (seen[p])
          begin
            dx = int'(plot_x) - int'(last_x[p]);
            dy = int'(plot_y) - int'(last_y[p]);
            check_value($sformatf("step of player %0d", p), 1,
                        ((dx < 0 ? -dx : dx) + (dy < 0 ? -dy : dy)) <= 1);
            if (pend[p] && (dx != 0 || dy != 0))
            begin
              check_value($sformatf("direction of player %0d", p), pend_dir[p],
                          dir_of(dx, dy));
              pend[p] = 1'b0;
            end
          end
          last_x[p] = plot_x;
          last_y[p] = plot_y;
          seen[p]   = 1'b1;
          player_plots++;
        end
      end
    end
    // Key taken after the plot so a same-edge plot keeps the old direction
    if (!reset && key_valid && key_ready && !key_op[4])
    begin
      pend[key_op[3:2]]     = 1'b1;
      pend_dir[key_op[3:2]] = int'(key_op[1:0]);
    end
  end

  initial
  begin : compare
    int         cnt [0:3];
    logic [7:0] exp_rank;
    wait (result_valid === 1'b1);
    // Result must stay up until reset
    repeat (4)
    begin
      @(negedge CLOCK_50);
      check_value("result_valid held", 1, result_valid);
    end
    cnt = '{default: 0};
    for (int x = 0; x < board_w_c; x++)
      for (int y = 0; y < board_h_c; y++)
        for (int p = 0; p < 4; p++)
          if (shadow[x][y] == player_colour_c[p])
            cnt[p]++;
    check_value("player plots in the round", (game_ticks_c + 1) * 4, player_plots);
    check_value("score_p0", cnt[0], score_p0);
    check_value("score_p1", cnt[1], score_p1);
    check_value("score_p2", cnt[2], score_p2);
    check_value("score_p3", cnt[3], score_p3);
    exp_rank = ref_rank(cnt[0], cnt[1], cnt[2], cnt[3]);
    check_value("rank_first", exp_rank[7:6], rank_first);
    check_value("rank_second", exp_rank[5:4], rank_second);
    check_value("rank_third", exp_rank[3:2], rank_third);
    check_value("rank_fourth", exp_rank[1:0], rank_fourth);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

  initial
  begin : watchdog
    repeat (limit_cycles_c) @(posedge CLOCK_50);
    $display("Timeout: no result after %0d clock cycles", limit_cycles_c);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire
